/* Makefile */
# Verilator build and run of the branch target buffer testbench

TOP := btb_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f project.f

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* associative_comparator.sv */
`timescale 1ns/1ps

module associative_comparator (
    input  btb_pkg::tag_t  src_tag,                 // Tag under test
    btb_lines_if.compare   lines,
    output logic           hit,
    output btb_pkg::line_t hit_line
);

    logic [btb_pkg::BTB_LINES-1:0] match;           // Per-line hit vector

    ////////////////////
    // Tag compare
    ////////////////////

    always_comb begin
        for (int i = 0; i < btb_pkg::BTB_LINES; i++) begin
            match[i] = lines.valid[i] && (lines.tag[i] == src_tag);
        end
    end

    ////////////////////
    // Priority encode
    ////////////////////

    // Scanned from the top down, so the lowest matching line wins
    always_comb begin
        hit      = 1'b0;
        hit_line = '0;                              // Line 0 on a miss
        for (int i = btb_pkg::BTB_LINES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit      = 1'b1;
                hit_line = btb_pkg::line_t'(i);
            end
        end
    end

endmodule

/* btb_lines_if.sv */
`timescale 1ns/1ps

interface btb_lines_if;

    logic [btb_pkg::BTB_LINES-1:0] valid;                   // One bit per line
    btb_pkg::tag_t                 tag    [btb_pkg::BTB_LINES];
    btb_pkg::pc_t                  target [btb_pkg::BTB_LINES];

    ////////////////////
    // Access views
    ////////////////////

    // Line registers own all three arrays
    modport storage (
        output valid,
        output tag,
        output target
    );

    modport compare (                                       // Lookup and update match
        input valid,
        input tag
    );

    modport result (                                        // Target read on a hit
        input target
    );

endinterface

/* btb_pkg.sv */
package btb_pkg;

    ////////////////////
    // Address geometry
    ////////////////////

    localparam int PC_WIDTH      = 32;                  // Fetch address width
    localparam int PC_ALIGN_BITS = 2;                   // Word-aligned instructions
    localparam int BTB_TAG_SIZE  = PC_WIDTH - PC_ALIGN_BITS;

    ////////////////////
    // Buffer geometry
    ////////////////////

    localparam int BTB_LINES     = 8;                   // Fully associative, no sets
    localparam int BTB_LINE_SIZE = $clog2(BTB_LINES);   // Line index width

    ////////////////////
    // Types
    ////////////////////

    typedef logic [PC_WIDTH-1:0]      pc_t;             // PCs and branch targets
    typedef logic [BTB_TAG_SIZE-1:0]  tag_t;            // PC minus alignment bits
    typedef logic [BTB_LINE_SIZE-1:0] line_t;

    // Fall-through stride when the buffer has no entry
    localparam pc_t PC_STEP = pc_t'(4);

endpackage

/* btb_predict_result.sv */
`timescale 1ns/1ps

module btb_predict_result (
    input  logic           clk,
    input  logic           reset,
    input  logic           lookup_valid,            // Fetch lookup strobe
    input  btb_pkg::pc_t   lookup_pc,
    input  logic           hit,                     // From lookup comparator
    input  btb_pkg::line_t hit_line,
    btb_lines_if.result    lines,
    output logic           pred_valid,
    output logic           pred_hit,
    output btb_pkg::line_t pred_line,
    output btb_pkg::pc_t   pred_next_pc
);

    btb_pkg::pc_t next_pc;                          // Unregistered prediction

    ////////////////////
    // Next PC select
    ////////////////////

    assign next_pc = hit ? lines.target[hit_line] : lookup_pc + btb_pkg::PC_STEP;

    ////////////////////
    // Answer register
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_valid   <= 1'b0;
            pred_hit     <= 1'b0;
            pred_line    <= '0;
            pred_next_pc <= '0;
        end else begin
            pred_valid <= lookup_valid;             // Single-cycle pulse
            if (lookup_valid) begin
                pred_hit     <= hit;
                pred_line    <= hit_line;
                pred_next_pc <= next_pc;            // Held until next lookup
            end
        end
    end

endmodule

/* btb_storage.sv */
`timescale 1ns/1ps

module btb_storage (
    input  logic           clk,
    input  logic           reset,
    input  logic           wr_en,
    input  btb_pkg::line_t wr_line,                 // Hit line or victim
    input  btb_pkg::tag_t  wr_tag,
    input  btb_pkg::pc_t   wr_target,
    btb_lines_if.storage   lines
);

    logic [btb_pkg::BTB_LINES-1:0] line_sel;        // One-hot write select

    ////////////////////
    // Write decode
    ////////////////////

    always_comb begin
        for (int i = 0; i < btb_pkg::BTB_LINES; i++) begin
            line_sel[i] = wr_en && (wr_line == btb_pkg::line_t'(i));
        end
    end

    ////////////////////
    // Valid bits
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            lines.valid <= '0;                      // Whole buffer empty
        end else begin
            for (int i = 0; i < btb_pkg::BTB_LINES; i++) begin
                if (line_sel[i]) begin
                    lines.valid[i] <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Tag and target
    ////////////////////

    // Tag rewritten even on a hit update; it is the same value
    always_ff @(posedge clk) begin
        for (int i = 0; i < btb_pkg::BTB_LINES; i++) begin
            if (line_sel[i]) begin
                lines.tag[i]    <= wr_tag;
                lines.target[i] <= wr_target;
            end
        end
    end

endmodule

/* btb_tb.sv */
`timescale 1ns/1ps

module btb_tb;

    localparam int OP_LOOKUP  = 0;
    localparam int OP_UPDATE  = 1;
    localparam int OP_BOTH    = 2;                   // Lookup and update together
    localparam int OP_RESET   = 3;
    localparam int MAX_ROWS   = 64;
    localparam int WAIT_LIMIT = 20;                  // Cycles to wait for pred_valid

    logic           clk;
    logic           reset;
    logic           lookup_valid;
    btb_pkg::pc_t   lookup_pc;
    logic           update_valid;
    btb_pkg::pc_t   update_pc;
    btb_pkg::pc_t   update_target;
    logic           pred_valid;
    logic           pred_hit;
    btb_pkg::line_t pred_line;
    btb_pkg::pc_t   pred_next_pc;

    ////////////////////
    // Operation table
    ////////////////////

    int             op_tab       [MAX_ROWS];
    btb_pkg::pc_t   lpc_tab      [MAX_ROWS];
    btb_pkg::pc_t   upc_tab      [MAX_ROWS];
    btb_pkg::pc_t   tgt_tab      [MAX_ROWS];
    logic           exp_hit_tab  [MAX_ROWS];
    btb_pkg::line_t exp_line_tab [MAX_ROWS];
    btb_pkg::pc_t   exp_next_tab [MAX_ROWS];
    int             row_count;

    // Reference model of the lines
    logic           ref_valid  [btb_pkg::BTB_LINES];
    btb_pkg::pc_t   ref_pc     [btb_pkg::BTB_LINES];
    btb_pkg::pc_t   ref_target [btb_pkg::BTB_LINES];
    int             ref_ptr;                          // Round-robin victim
    logic           held_hit;                         // Last answer on the outputs
    btb_pkg::line_t held_line;
    btb_pkg::pc_t   held_next;

    btb_pkg::pc_t   used_pcs [$];                     // Keeps random PCs distinct
    integer         seed;
    int             test_count;
    int             fail_count;
    int             row_errors;

    btb_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .lookup_valid  (lookup_valid),
        .lookup_pc     (lookup_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_target (update_target),
        .pred_valid    (pred_valid),
        .pred_hit      (pred_hit),
        .pred_line     (pred_line),
        .pred_next_pc  (pred_next_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    task automatic model_clear();
        for (int i = 0; i < btb_pkg::BTB_LINES; i++) begin
            ref_valid[i] = 1'b0;
        end
        ref_ptr   = 0;
        held_hit  = 1'b0;
        held_line = '0;
        held_next = '0;
    endtask

    // First valid line holding the same word address, -1 when absent
    function automatic int model_find(input btb_pkg::pc_t pc);
        int found;
        found = -1;
        for (int i = 0; i < btb_pkg::BTB_LINES; i++) begin
            if (found < 0 && ref_valid[i] && ref_pc[i][31:2] == pc[31:2]) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic model_write(input btb_pkg::pc_t pc, input btb_pkg::pc_t target);
        int line;
        line = model_find(pc);
        if (line < 0) begin
            line    = ref_ptr;                        // Allocate the victim
            ref_ptr = (ref_ptr + 1) % btb_pkg::BTB_LINES;
        end
        ref_valid[line]  = 1'b1;
        ref_pc[line]     = pc;
        ref_target[line] = target;
    endtask

    ////////////////////
    // Stimulus values
    ////////////////////

    function automatic btb_pkg::pc_t fresh_pc();
        btb_pkg::pc_t pc;
        bit           taken;
        do begin
            pc    = btb_pkg::pc_t'($random(seed)) & 32'hFFFF_FFFC;
            taken = 1'b0;
            foreach (used_pcs[k]) begin
                if (used_pcs[k] == pc) begin
                    taken = 1'b1;
                end
            end
        end while (taken);
        used_pcs.push_back(pc);
        return pc;
    endfunction

    function automatic btb_pkg::pc_t rand_target();
        return btb_pkg::pc_t'($random(seed)) & 32'hFFFF_FFFC;
    endfunction

    // Expectations come from the model state before the row's own update
    task automatic add_row(input int op, input btb_pkg::pc_t lpc,
                           input btb_pkg::pc_t upc, input btb_pkg::pc_t tgt);
        int line;
        line = model_find(lpc);
        op_tab[row_count]  = op;
        lpc_tab[row_count] = lpc;
        upc_tab[row_count] = upc;
        tgt_tab[row_count] = tgt;
        if (op == OP_UPDATE) begin
            exp_hit_tab[row_count]  = held_hit;       // No lookup, answer stays
            exp_line_tab[row_count] = held_line;
            exp_next_tab[row_count] = held_next;
        end else if (op == OP_RESET || line < 0) begin
            exp_hit_tab[row_count]  = 1'b0;
            exp_line_tab[row_count] = '0;
            exp_next_tab[row_count] = (op == OP_RESET) ? '0 : lpc + 32'd4;
        end else begin
            exp_hit_tab[row_count]  = 1'b1;
            exp_line_tab[row_count] = btb_pkg::line_t'(line);
            exp_next_tab[row_count] = ref_target[line];
        end
        held_hit  = exp_hit_tab[row_count];
        held_line = exp_line_tab[row_count];
        held_next = exp_next_tab[row_count];
        if (op == OP_UPDATE || op == OP_BOTH) begin
            model_write(upc, tgt);
        end
        if (op == OP_RESET) begin
            model_clear();
        end
        row_count++;
    endtask

    task automatic build_table();
        btb_pkg::pc_t fill_pc [10];
        btb_pkg::pc_t pc_new;
        row_count = 0;
        model_clear();
        fill_pc[0] = 32'h0000_1000;
        used_pcs.push_back(fill_pc[0]);
        for (int i = 1; i < 10; i++) begin
            fill_pc[i] = fresh_pc();
        end
        for (int i = 0; i < 3; i++) begin
            add_row(OP_LOOKUP, fresh_pc(), '0, '0);   // Empty buffer misses
        end
        for (int i = 0; i < 5; i++) begin
            add_row(OP_UPDATE, '0, fill_pc[i], rand_target());
            add_row(OP_LOOKUP, fill_pc[i], '0, '0);
        end
        add_row(OP_UPDATE, '0, fill_pc[0], rand_target());  // Rewrite line 0
        add_row(OP_LOOKUP, fill_pc[0], '0, '0);
        for (int i = 5; i < 10; i++) begin
            add_row(OP_UPDATE, '0, fill_pc[i], rand_target());
            add_row(OP_LOOKUP, fill_pc[i], '0, '0);
        end
        add_row(OP_LOOKUP, fill_pc[0], '0, '0);       // Evicted entries
        add_row(OP_LOOKUP, fill_pc[1], '0, '0);
        pc_new = fresh_pc();
        add_row(OP_BOTH, pc_new, pc_new, rand_target());
        add_row(OP_LOOKUP, pc_new, '0, '0);
        add_row(OP_RESET, '0, '0, '0);
        add_row(OP_LOOKUP, pc_new, '0, '0);
        add_row(OP_LOOKUP, fill_pc[8], '0, '0);
        pc_new = fresh_pc();
        add_row(OP_UPDATE, '0, pc_new, rand_target());
        add_row(OP_LOOKUP, pc_new, '0, '0);           // Refill from line 0
    endtask

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
            row_errors++;
        end
    endtask

    task automatic check_outputs(input int r);
        check_field("pred_hit", 32'(exp_hit_tab[r]), 32'(pred_hit));
        check_field("pred_line", 32'(exp_line_tab[r]), 32'(pred_line));
        check_field("pred_next_pc", exp_next_tab[r], pred_next_pc);
    endtask

    task automatic close_test(input int r, input string what);
        test_count++;
        if (row_errors == 0) begin
            $display("row %0d %s: ok", r, what);
        end else begin
            fail_count++;
            $display("row %0d %s: failed with %0d errors", r, what, row_errors);
        end
    endtask

    task automatic apply_row(input int r);
        int waited;
        row_errors = 0;
        if (op_tab[r] == OP_RESET) begin
            reset = 1'b1;
            repeat (3) @(posedge clk);
            #2;
            reset = 1'b0;
            check_field("pred_valid", 32'd0, 32'(pred_valid));
            check_outputs(r);
            close_test(r, "reset");
            return;
        end
        lookup_valid  = (op_tab[r] == OP_LOOKUP || op_tab[r] == OP_BOTH);
        lookup_pc     = lpc_tab[r];
        update_valid  = (op_tab[r] == OP_UPDATE || op_tab[r] == OP_BOTH);
        update_pc     = upc_tab[r];
        update_target = tgt_tab[r];
        @(posedge clk);
        #2;
        lookup_valid = 1'b0;                          // Strobes last one cycle
        update_valid = 1'b0;
        if (op_tab[r] == OP_UPDATE) begin
            check_field("pred_valid", 32'd0, 32'(pred_valid));   // Pulse already over
            check_outputs(r);
            close_test(r, "update");
            return;
        end
        waited = 0;
        while (!pred_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!pred_valid) begin
            $display("row %0d: no prediction arrived within %0d cycles for lookup of pc %h",
                     r, WAIT_LIMIT, lpc_tab[r]);
            row_errors++;
        end else begin
            check_outputs(r);
        end
        close_test(r, (op_tab[r] == OP_BOTH) ? "lookup with update" : "lookup");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed          = 25;
        reset         = 1'b1;
        lookup_valid  = 1'b0;
        lookup_pc     = '0;
        update_valid  = 1'b0;
        update_pc     = '0;
        update_target = '0;
        test_count    = 0;
        fail_count    = 0;
        build_table();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int r = 0; r < row_count; r++) begin
            apply_row(r);
        end
        $display("Summary: %0d tests, %0d passed, %0d failed",
                 test_count, test_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* btb_top.sv */
`timescale 1ns/1ps

module btb_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           lookup_valid,
    input  btb_pkg::pc_t   lookup_pc,
    input  logic           update_valid,
    input  btb_pkg::pc_t   update_pc,
    input  btb_pkg::pc_t   update_target,
    output logic           pred_valid,
    output logic           pred_hit,
    output btb_pkg::line_t pred_line,
    output btb_pkg::pc_t   pred_next_pc
);

    btb_pkg::tag_t  lookup_tag;
    btb_pkg::tag_t  update_tag;
    logic           lookup_hit;                     // Fetch side match
    btb_pkg::line_t lookup_line;
    logic           upd_hit;                        // Resolve side match
    btb_pkg::line_t upd_hit_line;
    logic           wr_en;
    btb_pkg::line_t wr_line;

    // Drop the word alignment bits
    assign lookup_tag = lookup_pc[btb_pkg::PC_WIDTH-1:btb_pkg::PC_ALIGN_BITS];
    assign update_tag = update_pc[btb_pkg::PC_WIDTH-1:btb_pkg::PC_ALIGN_BITS];

    btb_lines_if lines_i ();                        // Shared line arrays

    ////////////////////
    // Update path
    ////////////////////

    associative_comparator update_cmp_i (
        .src_tag  (update_tag),
        .lines    (lines_i.compare),
        .hit      (upd_hit),
        .hit_line (upd_hit_line)
    );

    btb_update_ctrl update_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .update_valid (update_valid),
        .upd_hit      (upd_hit),
        .upd_hit_line (upd_hit_line),
        .wr_en        (wr_en),
        .wr_line      (wr_line)
    );

    btb_storage storage_i (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_line   (wr_line),
        .wr_tag    (update_tag),
        .wr_target (update_target),
        .lines     (lines_i.storage)
    );

    ////////////////////
    // Lookup path
    ////////////////////

    associative_comparator lookup_cmp_i (
        .src_tag  (lookup_tag),
        .lines    (lines_i.compare),
        .hit      (lookup_hit),
        .hit_line (lookup_line)
    );

    btb_predict_result result_i (
        .clk          (clk),
        .reset        (reset),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .hit          (lookup_hit),
        .hit_line     (lookup_line),
        .lines        (lines_i.result),
        .pred_valid   (pred_valid),
        .pred_hit     (pred_hit),
        .pred_line    (pred_line),
        .pred_next_pc (pred_next_pc)
    );

endmodule

/* btb_update_ctrl.sv */
`timescale 1ns/1ps

module btb_update_ctrl (
    input  logic           clk,
    input  logic           reset,
    input  logic           update_valid,            // Resolved branch strobe
    input  logic           upd_hit,                 // Branch PC already stored
    input  btb_pkg::line_t upd_hit_line,
    output logic           wr_en,
    output btb_pkg::line_t wr_line
);

    localparam btb_pkg::line_t LAST_LINE = btb_pkg::line_t'(btb_pkg::BTB_LINES - 1);

    btb_pkg::line_t victim_ptr;                     // Next line to replace
    logic           fill;                           // Update allocates a line

    ////////////////////
    // Write decision
    ////////////////////

    assign fill    = update_valid && !upd_hit;
    assign wr_en   = update_valid;                  // Every update writes
    assign wr_line = upd_hit ? upd_hit_line : victim_ptr;

    ////////////////////
    // Round-robin victim
    ////////////////////

    // Only allocating updates move the pointer; rewrites of a stored
    // branch keep the replacement order intact
    always_ff @(posedge clk) begin
        if (reset) begin
            victim_ptr <= '0;
        end else if (fill) begin
            if (victim_ptr == LAST_LINE) begin
                victim_ptr <= '0;                   // Wrap after the last line
            end else begin
                victim_ptr <= victim_ptr + 1'b1;
            end
        end
    end

endmodule

/* project.f */
btb_pkg.sv
btb_lines_if.sv
associative_comparator.sv
btb_update_ctrl.sv
btb_storage.sv
btb_predict_result.sv
btb_top.sv
btb_tb.sv
